//--- tb.f
ddr_pkg.sv
ddr_bank_if.sv
ddr_cmd_dispatch.sv
ddr_bank.sv
ddr_rsp_collect.sv
apb_ddr_regs.sv
ddr_ctrl_top.sv
ddr_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module ddr_ctrl_tb -Mdir obj_dir

out=$(./obj_dir/Vddr_ctrl_tb)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

//--- ddr_ctrl_tb.sv
// Self-checking testbench for the DDR-style controller subsystem.
// A reference model tracks memory words, open rows and the expected counters;
// assertions compare read data and register values against it.

`timescale 1ns/1ns

module ddr_ctrl_tb;
    import ddr_pkg::*;

    logic       i_clk;
    logic       i_arst_n;
    logic       i_mem_req;
    logic       i_mem_we;
    addr_t      i_mem_addr;
    data_t      i_mem_wdata;
    logic       o_mem_rvalid;
    data_t      o_mem_rdata;
    logic       i_apb_psel;
    logic       i_apb_penable;
    logic       i_apb_pwrite;
    apb_addr_t  i_apb_paddr;
    data_t      i_apb_pwdata;
    data_t      o_apb_prdata;
    logic       o_init_calib_done;

    // Reference model
    data_t      mem_model [addr_t];
    row_t       open_row [NUM_BANKS];
    bit         open_vld [NUM_BANKS];
    int         exp_hit;
    int         exp_miss;
    int         exp_drop;
    bit         calib_seen;
    int         reads_issued;
    int         rvalid_seen;
    int         errors;
    string      test_name;
    addr_t      addr_list [$];

    // Expected read for each request, delayed until o_mem_rvalid is due
    logic       rd_chk;
    data_t      rd_exp;
    logic [4:1] chk_pipe;
    data_t      exp_pipe [1:4];

    ddr_ctrl_top i_dut (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_mem_req(i_mem_req),
        .i_mem_we(i_mem_we),
        .i_mem_addr(i_mem_addr),
        .i_mem_wdata(i_mem_wdata),
        .o_mem_rvalid(o_mem_rvalid),
        .o_mem_rdata(o_mem_rdata),
        .i_apb_psel(i_apb_psel),
        .i_apb_penable(i_apb_penable),
        .i_apb_pwrite(i_apb_pwrite),
        .i_apb_paddr(i_apb_paddr),
        .i_apb_pwdata(i_apb_pwdata),
        .o_apb_prdata(o_apb_prdata),
        .o_init_calib_done(o_init_calib_done)
    );

    always #50 i_clk = ~i_clk;

    // Stage 4 lines up with o_mem_rvalid, which rises after edge N+3
    always @(posedge i_clk) begin
        chk_pipe    <= {chk_pipe[3:1], rd_chk};
        exp_pipe[1] <= rd_exp;
        exp_pipe[2] <= exp_pipe[1];
        exp_pipe[3] <= exp_pipe[2];
        exp_pipe[4] <= exp_pipe[3];
    end

    always @(negedge i_clk) begin
        if (i_arst_n && o_mem_rvalid) begin
            rvalid_seen++;
        end
    end

    a_read_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        chk_pipe[4] |-> o_mem_rvalid)
    else begin
        errors++;
        $display("Read in %s got no o_mem_rvalid 3 cycles after its strobe", test_name);
    end

    a_read_data: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        chk_pipe[4] |-> (o_mem_rdata == exp_pipe[4]))
    else begin
        errors++;
        $display("Error: %s read data expected %h actual %h", test_name,
                 $sampled(exp_pipe[4]), $sampled(o_mem_rdata));
    end

    a_no_extra_rvalid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_mem_rvalid |-> chk_pipe[4])
    else begin
        errors++;
        $display("In %s o_mem_rvalid rose without an accepted read", test_name);
    end

    a_calib_stays: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        o_init_calib_done |=> o_init_calib_done)
    else begin
        errors++;
        $display("o_init_calib_done dropped after calibration");
    end

    function automatic addr_t make_addr(input row_t r, input col_t c, input bank_idx_t b);
        return {r, c, b};
    endfunction

    task automatic report_and_finish();
        $display("Errors: %0d, read responses: %0d", errors, rvalid_seen);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // Drives one request and updates the model as the DUT will see it
    task automatic mem_access(input logic we, input addr_t addr, input data_t wdata);
        bank_idx_t b;
        row_t      r;
        b = addr[BANK_W-1:0];
        r = addr[ADDR_W-1 -: ROW_W];
        @(posedge i_clk);
        i_mem_req   <= 1'b1;
        i_mem_we    <= we;
        i_mem_addr  <= addr;
        i_mem_wdata <= wdata;
        rd_chk      <= calib_seen && !we;
        rd_exp      <= (!we && mem_model.exists(addr)) ? mem_model[addr] : '0;
        if (!calib_seen) begin
            exp_drop++;
        end else begin
            if (open_vld[b] && open_row[b] == r) begin
                exp_hit++;
            end else begin
                exp_miss++;
            end
            open_row[b] = r;
            open_vld[b] = 1'b1;
            if (we) begin
                mem_model[addr] = wdata;
            end else begin
                reads_issued++;
            end
        end
    endtask

    task automatic mem_idle();
        @(posedge i_clk);
        i_mem_req <= 1'b0;
        rd_chk    <= 1'b0;
    endtask

    // Waits for all read responses, then for the counters to settle
    task automatic drain_reads();
        int cycles;
        cycles = 0;
        while (rvalid_seen != reads_issued && cycles < 50) begin
            @(posedge i_clk);
            cycles++;
        end
        if (rvalid_seen != reads_issued) begin
            $display("Timeout waiting for read responses in %s", test_name);
            errors++;
            report_and_finish();
        end else begin
            repeat (4) @(posedge i_clk);
        end
    endtask

    task automatic wait_calib();
        int cycles;
        cycles = 0;
        while (!o_init_calib_done && cycles < 64) begin
            @(negedge i_clk);
            cycles++;
        end
        if (!o_init_calib_done) begin
            $display("Timeout waiting for calibration to complete");
            errors++;
            report_and_finish();
        end else begin
            calib_seen = 1'b1;
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input data_t wdata);
        @(posedge i_clk);
        i_apb_psel    <= 1'b1;
        i_apb_pwrite  <= 1'b1;
        i_apb_paddr   <= addr;
        i_apb_pwdata  <= wdata;
        @(posedge i_clk);
        i_apb_penable <= 1'b1;
        @(posedge i_clk);
        i_apb_psel    <= 1'b0;
        i_apb_penable <= 1'b0;
        i_apb_pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input data_t exp, input string name);
        data_t got;
        @(posedge i_clk);
        i_apb_psel    <= 1'b1;
        i_apb_pwrite  <= 1'b0;
        i_apb_paddr   <= addr;
        @(posedge i_clk);
        i_apb_penable <= 1'b1;
        // Sample in the middle of the access phase
        @(negedge i_clk);
        got = o_apb_prdata;
        @(posedge i_clk);
        i_apb_psel    <= 1'b0;
        i_apb_penable <= 1'b0;
        assert (got == exp) else begin
            errors++;
            $display("Error: %s expected %0d actual %0d", name, exp, got);
        end
    endtask

    task automatic check_counters(input string name);
        apb_read(REG_HIT_CNT, data_t'(exp_hit), {name, " hit count"});
        apb_read(REG_MISS_CNT, data_t'(exp_miss), {name, " miss count"});
        apb_read(REG_DROP_CNT, data_t'(exp_drop), {name, " drop count"});
    endtask

    initial begin
        int    seed;
        addr_t a;
        seed = $urandom(56);
        i_clk = 1'b0;
        i_arst_n = 1'b0;
        i_mem_req = 1'b0;
        i_mem_we = 1'b0;
        i_mem_addr = '0;
        i_mem_wdata = '0;
        i_apb_psel = 1'b0;
        i_apb_penable = 1'b0;
        i_apb_pwrite = 1'b0;
        i_apb_paddr = '0;
        i_apb_pwdata = '0;
        rd_chk = 1'b0;
        rd_exp = '0;
        chk_pipe = '0;
        errors = 0;
        exp_hit = 0;
        exp_miss = 0;
        exp_drop = 0;
        reads_issued = 0;
        rvalid_seen = 0;
        calib_seen = 1'b0;
        repeat (3) @(posedge i_clk);
        i_arst_n <= 1'b1;

        test_name = "calibration";
        @(negedge i_clk);
        assert (!o_init_calib_done) else begin
            errors++;
            $display("Error: %s expected 0 actual %0d", test_name, o_init_calib_done);
        end

        // Requests before calibration completes are dropped
        test_name = "early_requests";
        for (int i = 0; i < 3; i++) begin
            mem_access(1'b0, addr_t'($urandom), '0);
        end
        mem_idle();
        test_name = "calibration";
        wait_calib();
        apb_read(REG_STATUS, 32'd1, "calibration status");
        check_counters("early_requests");

        test_name = "write_read";
        for (int i = 0; i < 16; i++) begin
            a = make_addr(row_t'($urandom), col_t'($urandom), bank_idx_t'(i % NUM_BANKS));
            addr_list.push_back(a);
            mem_access(1'b1, a, $urandom);
        end
        foreach (addr_list[i]) begin
            mem_access(1'b0, addr_list[i], '0);
        end
        mem_idle();
        drain_reads();
        check_counters("write_read");

        // Same-row accesses hit, a new row misses and becomes open
        test_name = "row_hit_miss";
        for (int b = 0; b < NUM_BANKS; b++) begin
            mem_access(1'b1, make_addr(4'd3, 4'd0, bank_idx_t'(b)), $urandom);
            mem_access(1'b1, make_addr(4'd3, 4'd1, bank_idx_t'(b)), $urandom);
            mem_access(1'b0, make_addr(4'd3, 4'd0, bank_idx_t'(b)), '0);
            mem_access(1'b1, make_addr(4'd5, 4'd2, bank_idx_t'(b)), $urandom);
            mem_access(1'b0, make_addr(4'd5, 4'd2, bank_idx_t'(b)), '0);
            mem_access(1'b0, make_addr(4'd3, 4'd1, bank_idx_t'(b)), '0);
        end
        mem_idle();
        drain_reads();
        check_counters("row_hit_miss");

        test_name = "pipelining";
        for (int i = addr_list.size() - 1; i >= 0; i--) begin
            mem_access(1'b0, addr_list[i], '0);
        end
        mem_idle();
        drain_reads();

        test_name = "counter_clear";
        apb_write(REG_CTRL, 32'd1);
        exp_hit = 0;
        exp_miss = 0;
        exp_drop = 0;
        check_counters("counter_clear");
        mem_access(1'b0, addr_list[0], '0);
        mem_access(1'b0, addr_list[0], '0);
        mem_access(1'b0, addr_list[5], '0);
        mem_idle();
        drain_reads();
        check_counters("after_clear");

        report_and_finish();
    end

endmodule

//--- ddr_ctrl_top.sv
// Top level of the DDR-style controller subsystem.
// Memory requests and APB access share i_clk; the banks are connected
// through an array of bank interfaces.

`timescale 1ns/1ns

module ddr_ctrl_top (
    input  logic                i_clk,
    input  logic                i_arst_n,
    // Memory request port
    input  logic                i_mem_req,
    input  logic                i_mem_we,
    input  ddr_pkg::addr_t      i_mem_addr,
    input  ddr_pkg::data_t      i_mem_wdata,
    output logic                o_mem_rvalid,
    output ddr_pkg::data_t      o_mem_rdata,
    // APB control port
    input  logic                i_apb_psel,
    input  logic                i_apb_penable,
    input  logic                i_apb_pwrite,
    input  ddr_pkg::apb_addr_t  i_apb_paddr,
    input  ddr_pkg::data_t      i_apb_pwdata,
    output ddr_pkg::data_t      o_apb_prdata,
    output logic                o_init_calib_done
);
    import ddr_pkg::*;

    logic hit_pulse;
    logic miss_pulse;
    logic drop_pulse;

    ddr_bank_if bank_if [0:NUM_BANKS-1] ();

    ddr_cmd_dispatch disp0 (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_mem_req(i_mem_req),
        .i_mem_we(i_mem_we),
        .i_mem_addr(i_mem_addr),
        .i_mem_wdata(i_mem_wdata),
        .o_init_calib_done(o_init_calib_done),
        .o_drop(drop_pulse),
        .bank_if(bank_if)
    );

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        ddr_bank bank0 (
            .i_clk(i_clk),
            .i_arst_n(i_arst_n),
            .bus(bank_if[g])
        );
    end

    ddr_rsp_collect collect0 (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .bank_if(bank_if),
        .o_mem_rvalid(o_mem_rvalid),
        .o_mem_rdata(o_mem_rdata),
        .o_hit(hit_pulse),
        .o_miss(miss_pulse)
    );

    apb_ddr_regs regs0 (
        .i_clk(i_clk),
        .i_arst_n(i_arst_n),
        .i_apb_psel(i_apb_psel),
        .i_apb_penable(i_apb_penable),
        .i_apb_pwrite(i_apb_pwrite),
        .i_apb_paddr(i_apb_paddr),
        .i_apb_pwdata(i_apb_pwdata),
        .o_apb_prdata(o_apb_prdata),
        .i_init_calib_done(o_init_calib_done),
        .i_hit(hit_pulse),
        .i_miss(miss_pulse),
        .i_drop(drop_pulse)
    );

endmodule

//--- apb_ddr_regs.sv
// APB status and statistics registers of the memory controller.
// Zero wait states: writes land at the end of the access phase and
// read data is decoded combinationally from the address.

`timescale 1ns/1ns

module apb_ddr_regs (
    input  logic                i_clk,
    input  logic                i_arst_n,
    input  logic                i_apb_psel,
    input  logic                i_apb_penable,
    input  logic                i_apb_pwrite,
    input  ddr_pkg::apb_addr_t  i_apb_paddr,
    input  ddr_pkg::data_t      i_apb_pwdata,
    output ddr_pkg::data_t      o_apb_prdata,
    input  logic                i_init_calib_done,
    input  logic                i_hit,
    input  logic                i_miss,
    input  logic                i_drop
);
    import ddr_pkg::*;

    cnt_t  hit_cnt;
    cnt_t  miss_cnt;
    cnt_t  drop_cnt;
    logic  apb_wr;
    logic  cnt_clear;

    assign apb_wr    = i_apb_psel && i_apb_penable && i_apb_pwrite;
    assign cnt_clear = apb_wr && (i_apb_paddr == REG_CTRL) && i_apb_pwdata[0];

    // Counters wrap on overflow; a clear takes priority over a new event
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
            drop_cnt <= '0;
        end else if (cnt_clear) begin
            hit_cnt  <= '0;
            miss_cnt <= '0;
            drop_cnt <= '0;
        end else begin
            if (i_hit) begin
                hit_cnt <= hit_cnt + 1'b1;
            end
            if (i_miss) begin
                miss_cnt <= miss_cnt + 1'b1;
            end
            if (i_drop) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    // Read decode
    always_comb begin
        o_apb_prdata = '0;
        if (i_apb_psel && !i_apb_pwrite) begin
            case (i_apb_paddr)
                REG_STATUS:   o_apb_prdata = DATA_W'(i_init_calib_done);
                REG_HIT_CNT:  o_apb_prdata = DATA_W'(hit_cnt);
                REG_MISS_CNT: o_apb_prdata = DATA_W'(miss_cnt);
                REG_DROP_CNT: o_apb_prdata = DATA_W'(drop_cnt);
                default:      o_apb_prdata = '0;
            endcase
        end
    end

    a_penable_with_psel: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        i_apb_penable |-> i_apb_psel
    );

endmodule

//--- ddr_rsp_collect.sv
// Merges the bank responses into one read port.
// Also turns the per-bank access and hit signals into hit and miss pulses
// for the statistics counters.

`timescale 1ns/1ns

module ddr_rsp_collect (
    input  logic              i_clk,
    input  logic              i_arst_n,
    ddr_bank_if.mon           bank_if [0:ddr_pkg::NUM_BANKS-1],
    output logic              o_mem_rvalid,
    output ddr_pkg::data_t    o_mem_rdata,
    output logic              o_hit,
    output logic              o_miss
);
    import ddr_pkg::*;

    logic [NUM_BANKS-1:0]   rvalid_vec;
    logic [NUM_BANKS-1:0]   acc_vec;
    logic [NUM_BANKS-1:0]   hit_vec;
    data_t                  rdata_arr [0:NUM_BANKS-1];
    data_t                  rdata_sel;

    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_gather
        assign rvalid_vec[g] = bank_if[g].rvalid;
        assign acc_vec[g]    = bank_if[g].acc;
        assign hit_vec[g]    = bank_if[g].hit;
        assign rdata_arr[g]  = bank_if[g].rdata;
    end

    // AND-OR select, at most one bank answers per cycle
    always_comb begin
        rdata_sel = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (rvalid_vec[i]) begin
                rdata_sel = rdata_sel | rdata_arr[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_mem_rvalid <= 1'b0;
            o_hit        <= 1'b0;
            o_miss       <= 1'b0;
        end else begin
            o_mem_rvalid <= |rvalid_vec;
            o_hit        <= |(acc_vec & hit_vec);
            o_miss       <= |(acc_vec & ~hit_vec);
        end
    end

    always_ff @(posedge i_clk) begin
        if (|rvalid_vec) begin
            o_mem_rdata <= rdata_sel;
        end
    end

    a_rvalid_onehot: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        $onehot0(rvalid_vec)
    );

    a_acc_onehot: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        $onehot0(acc_vec)
    );

endmodule

//--- ddr_bank.sv
// One bank engine with its own word storage and open-row tracking.
// Reads come back one cycle after the request; acc and hit follow the
// request combinationally so the collector sees them in the same cycle.

`timescale 1ns/1ns

module ddr_bank (
    input  logic      i_clk,
    input  logic      i_arst_n,
    ddr_bank_if.bank  bus
);
    import ddr_pkg::*;

    data_t                     mem [0:BANK_DEPTH-1];
    logic [ROW_W+COL_W-1:0]    word_idx;
    row_t                      open_row;
    logic                      open_vld;
    logic                      rvalid_q;
    data_t                     rdata_q;

    assign word_idx = {bus.row, bus.col};

    // Open-row bookkeeping
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            open_row <= '0;
            open_vld <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req && !bus.we;
            if (bus.req) begin
                open_row <= bus.row;
                open_vld <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus.req && bus.we) begin
            mem[word_idx] <= bus.wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus.req && !bus.we) begin
            rdata_q <= mem[word_idx];
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;
    assign bus.acc    = bus.req;
    // First access after reset always misses, open_vld is still low
    assign bus.hit    = open_vld && (open_row == bus.row);

endmodule

//--- ddr_cmd_dispatch.sv
// Calibration sequencer and request decoder in front of the bank engines.
// Requests pass two register stages before they reach the selected bank;
// requests seen before calibration completes are dropped and flagged.

`timescale 1ns/1ns

module ddr_cmd_dispatch (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_mem_req,
    input  logic              i_mem_we,
    input  ddr_pkg::addr_t    i_mem_addr,
    input  ddr_pkg::data_t    i_mem_wdata,
    output logic              o_init_calib_done,
    output logic              o_drop,
    ddr_bank_if.disp          bank_if [0:ddr_pkg::NUM_BANKS-1]
);
    import ddr_pkg::*;

    calib_state_t           calib_state;
    logic [CALIB_W-1:0]     calib_cnt;

    // Decode stage
    logic                   s1_valid;
    logic                   s1_we;
    bank_idx_t              s1_bank;
    row_t                   s1_row;
    col_t                   s1_col;
    data_t                  s1_wdata;

    // Issue stage towards the banks
    logic [NUM_BANKS-1:0]   req_q;
    logic                   s2_we;
    row_t                   s2_row;
    col_t                   s2_col;
    data_t                  s2_wdata;

    // Controller stays idle for CALIB_CYCLES after reset release
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            calib_state <= CAL_IDLE;
            calib_cnt   <= '0;
        end else begin
            case (calib_state)
                CAL_IDLE: begin
                    calib_state <= CAL_RUN;
                    calib_cnt   <= CALIB_W'(1);
                end
                CAL_RUN: begin
                    if (calib_cnt == CALIB_W'(CALIB_CYCLES - 1)) begin
                        calib_state <= CAL_DONE;
                    end
                    calib_cnt <= calib_cnt + 1'b1;
                end
                default: calib_state <= CAL_DONE;
            endcase
        end
    end

    assign o_init_calib_done = (calib_state == CAL_DONE);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            s1_valid <= 1'b0;
            o_drop   <= 1'b0;
            req_q    <= '0;
        end else begin
            s1_valid <= i_mem_req && o_init_calib_done;
            o_drop   <= i_mem_req && !o_init_calib_done;
            for (int i = 0; i < NUM_BANKS; i++) begin
                req_q[i] <= s1_valid && (s1_bank == bank_idx_t'(i));
            end
        end
    end

    // Field split, bank index sits in the low address bits
    always_ff @(posedge i_clk) begin
        s1_we    <= i_mem_we;
        s1_bank  <= i_mem_addr[BANK_W-1:0];
        s1_col   <= i_mem_addr[BANK_W +: COL_W];
        s1_row   <= i_mem_addr[BANK_W + COL_W +: ROW_W];
        s1_wdata <= i_mem_wdata;
        s2_we    <= s1_we;
        s2_row   <= s1_row;
        s2_col   <= s1_col;
        s2_wdata <= s1_wdata;
    end

    // Payload is shared, only the strobe is per bank
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank_drv
        assign bank_if[g].req   = req_q[g];
        assign bank_if[g].we    = s2_we;
        assign bank_if[g].row   = s2_row;
        assign bank_if[g].col   = s2_col;
        assign bank_if[g].wdata = s2_wdata;
    end

    a_no_req_before_calib: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (|req_q) |-> (calib_state == CAL_DONE)
    );

    a_one_bank_req: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        $onehot0(req_q)
    );

endmodule

//--- ddr_bank_if.sv
// Request and response signals between the dispatcher and one bank engine.
// The collector watches the response side through the mon modport.

`timescale 1ns/1ns

interface ddr_bank_if;
    import ddr_pkg::*;

    // Request side, one-cycle strobe with its payload
    logic  req;
    logic  we;
    row_t  row;
    col_t  col;
    data_t wdata;

    // Response side
    logic  rvalid;
    data_t rdata;
    logic  acc;
    logic  hit;

    modport disp (
        output req, we, row, col, wdata
    );

    modport bank (
        input  req, we, row, col, wdata,
        output rvalid, rdata, acc, hit
    );

    modport mon (
        input rvalid, rdata, acc, hit
    );

endinterface

//--- ddr_pkg.sv
// Shared widths, types and register map of the DDR-style controller.
// Every RTL file imports this package inside its module body.

package ddr_pkg;

    // Memory geometry, address is {row, col, bank} from MSB to LSB
    localparam int NUM_BANKS    = 4;
    localparam int BANK_W       = 2;
    localparam int ROW_W        = 4;
    localparam int COL_W        = 4;
    localparam int ADDR_W       = 10;
    localparam int DATA_W       = 32;
    localparam int BANK_DEPTH   = 2 ** (ROW_W + COL_W);

    localparam int CNT_W        = 16;
    localparam int CALIB_CYCLES = 16;
    localparam int CALIB_W      = $clog2(CALIB_CYCLES);
    localparam int APB_ADDR_W   = 5;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [ROW_W-1:0]      row_t;
    typedef logic [COL_W-1:0]      col_t;
    typedef logic [BANK_W-1:0]     bank_idx_t;
    typedef logic [CNT_W-1:0]      cnt_t;
    typedef logic [APB_ADDR_W-1:0] apb_addr_t;

    typedef enum logic [1:0] {
        CAL_IDLE,
        CAL_RUN,
        CAL_DONE
    } calib_state_t;

    // APB register offsets
    localparam apb_addr_t REG_STATUS   = 5'h00;
    localparam apb_addr_t REG_HIT_CNT  = 5'h04;
    localparam apb_addr_t REG_MISS_CNT = 5'h08;
    localparam apb_addr_t REG_DROP_CNT = 5'h0C;
    localparam apb_addr_t REG_CTRL     = 5'h10;

endpackage
